// ==== files.f ====
+incdir+.
bridge_pkg.sv
afifo_channel.sv
lane_merge.sv
dual_lane_bridge.sv
tb_dual_lane_bridge.sv

// ==== Bender.yml ====
package:
  name: dual_lane_bridge

sources:
  - include_dirs:
      - .
    files:
      - bridge_pkg.sv
      - afifo_channel.sv
      - lane_merge.sv
      - dual_lane_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dual_lane_bridge.sv

// ==== tb_dual_lane_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module tb_dual_lane_bridge;

   localparam logic [31:0] seed         = 32'h146a;
   localparam int          flood_len    = 24;  // wrclk cycles of writing while ack is held.
   localparam int          total_writes = 30 + 30 + 60 + 60 + flood_len;
   localparam int          cycle_limit  = 20 * total_writes + 200;

   logic                wrclk;
   logic                rdclk;
   logic                arst_n;
   bridge_pkg::sample_t a_data;
   logic                a_write;
   logic                a_full;
   logic                a_overflow;
   bridge_pkg::event_t  b_data;
   logic                b_write;
   logic                b_full;
   logic                b_overflow;
   bridge_pkg::wb_req_t wb;
   logic                wb_ack;

   bridge_pkg::sample_t a_q[$];  // accepted lane a words, oldest first.
   bridge_pkg::event_t  b_q[$];
   string               test_name;
   logic [31:0]         a_rng;
   logic [31:0]         b_rng;
   logic [31:0]         ack_rng;
   int                  max_delay;
   int                  delay;
   logic                hold_ack;
   int                  overflows;
   int                  cycles;
   logic                stb_waiting;
   logic [15:0]         held_adr;
   logic [31:0]         held_dat;

   dual_lane_bridge u_dual_lane_bridge (
      .wrclk      (wrclk),
      .rdclk      (rdclk),
      .arst_n     (arst_n),
      .a_data     (a_data),
      .a_write    (a_write),
      .a_full     (a_full),
      .a_overflow (a_overflow),
      .b_data     (b_data),
      .b_write    (b_write),
      .b_full     (b_full),
      .b_overflow (b_overflow),
      .wb         (wb),
      .wb_ack     (wb_ack)
   );

   initial begin
      rdclk = 1'b0;
      forever #5 rdclk = ~rdclk;
   end

   initial begin
      wrclk = 1'b0;
      forever #7 wrclk = ~wrclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // returns {adr, dat} of the bus write that a payload must produce.
   function automatic logic [47:0] expected_write(input bridge_pkg::lane_e lane,
                                                  input logic [23:0] payload);
      int          s;
      logic [31:0] dat;
      logic [15:0] adr;
      if (lane == bridge_pkg::lane_a) begin
         s   = $signed(payload[15:0]);
         dat = s;
         adr = `BRIDGE_LANE_A_ADR;
      end else begin
         dat = {8'h00, payload[23:16], payload[15:0]};  // code above stamp.
         adr = `BRIDGE_LANE_B_ADR;
      end
      return {adr, dat};
   endfunction

   task automatic stop_with_failure();
      $display("tests failed");
      $fatal(1, "simulation stopped at first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [47:0] exp,
                                  input logic [47:0] act);
      $display("Error: test %s, expected %h, actual %h", name, exp, act);
      stop_with_failure();
   endtask

   task automatic report_problem(input string what);
      $display("test %s: %s", test_name, what);
      stop_with_failure();
   endtask

   // writes until n words were accepted, retrying after an overflow.
   task automatic drive_a(input int n);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge wrclk);
         if (a_write && !a_full) begin
            sent++;
         end
         if (sent < n) begin
            a_rng = xorshift32(a_rng);
            a_data  <= a_rng[15:0];
            a_write <= 1'b1;
         end else begin
            a_write <= 1'b0;
         end
      end
   endtask

   task automatic drive_b(input int n);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge wrclk);
         if (b_write && !b_full) begin
            sent++;
         end
         if (sent < n) begin
            b_rng = xorshift32(b_rng);
            b_data  <= bridge_pkg::event_t'(b_rng[23:0]);
            b_write <= 1'b1;
         end else begin
            b_write <= 1'b0;
         end
      end
   endtask

   task automatic flood_a(input int n);
      repeat (n) begin
         @(posedge wrclk);
         a_rng = xorshift32(a_rng);
         a_data  <= a_rng[15:0];
         a_write <= 1'b1;
      end
      @(posedge wrclk);
      a_write <= 1'b0;
   endtask

   task automatic wait_drain();
      @(posedge rdclk);
      while (a_q.size() != 0 || b_q.size() != 0 || wb.cyc) begin
         @(posedge rdclk);
      end
   endtask

   task automatic check_write();
      logic [47:0]       exp;
      bridge_pkg::lane_e lane;
      lane = bridge_pkg::lane_b;
      if (wb.adr == `BRIDGE_LANE_A_ADR) begin
         lane = bridge_pkg::lane_a;
      end else begin
         assert (wb.adr == `BRIDGE_LANE_B_ADR)
            else report_problem("a bus write went to an address that names no lane");
      end
      if (lane == bridge_pkg::lane_a) begin
         assert (a_q.size() > 0)
            else report_problem("a lane a word came out that was never written");
         exp = expected_write(lane, {8'h00, a_q.pop_front()});
      end else begin
         assert (b_q.size() > 0)
            else report_problem("a lane b word came out that was never written");
         exp = expected_write(lane, b_q.pop_front());
      end
      assert ({wb.adr, wb.dat} == exp) else report_mismatch(test_name, exp, {wb.adr, wb.dat});
      assert (wb.cyc && wb.we && wb.sel == 4'hf)
         else report_problem("cyc, we or sel was low during a bus write");
   endtask

   // the write side monitor sees the values the channels latch.
   always @(posedge wrclk) begin
      if (arst_n) begin
         assert (a_overflow == (a_write && a_full))
            else report_mismatch(test_name, 48'(a_write && a_full), 48'(a_overflow));
         assert (b_overflow == (b_write && b_full))
            else report_mismatch(test_name, 48'(b_write && b_full), 48'(b_overflow));
         if (a_write && !a_full) begin
            a_q.push_back(a_data);
         end
         if (b_write && !b_full) begin
            b_q.push_back(b_data);
         end
         if (a_overflow || b_overflow) begin
            overflows++;
         end
      end
   end

   // wishbone slave that acks after a random wait.
   always @(posedge rdclk) begin
      if (!arst_n) begin
         wb_ack <= 1'b0;
         delay  <= 0;
      end else if (wb.stb && wb_ack) begin
         ack_rng = xorshift32(ack_rng);
         wb_ack <= 1'b0;
         delay  <= ack_rng % (max_delay + 1);
      end else if (wb.stb && !hold_ack) begin
         if (delay == 0) begin
            wb_ack <= 1'b1;
         end else begin
            delay <= delay - 1;
         end
      end
   end

   // scoreboard side of the bus.
   always @(posedge rdclk) begin
      if (arst_n) begin
         if (stb_waiting) begin
            assert (wb.stb) else report_problem("stb fell before ack");
            assert (wb.adr == held_adr && wb.dat == held_dat)
               else report_mismatch(test_name, {held_adr, held_dat}, {wb.adr, wb.dat});
         end
         stb_waiting = wb.stb && !wb_ack;
         held_adr    = wb.adr;
         held_dat    = wb.dat;
         if (wb.stb && wb_ack) begin
            check_write();
         end
      end
   end

   always @(posedge rdclk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: the bridge did not deliver all words within %0d cycles", cycle_limit);
         stop_with_failure();
      end
   end

   initial begin
      arst_n      = 1'b0;
      a_data      = '0;
      a_write     = 1'b0;
      b_data      = '0;
      b_write     = 1'b0;
      wb_ack      = 1'b0;
      hold_ack    = 1'b0;
      max_delay   = 0;
      delay       = 0;
      overflows   = 0;
      cycles      = 0;
      stb_waiting = 1'b0;
      a_rng       = seed;
      b_rng       = seed ^ 32'hffff_0000;
      ack_rng     = seed ^ 32'h0000_ffff;
      test_name   = "reset";
      repeat (3) @(posedge rdclk);
      arst_n <= 1'b1;
      repeat (6) @(posedge rdclk);
      assert ({wb.cyc, wb.stb, a_full, b_full, a_overflow, b_overflow} == 6'b0)
         else report_mismatch(test_name, 48'h0,
                              48'({wb.cyc, wb.stb, a_full, b_full, a_overflow, b_overflow}));

      test_name = "lane_a_only";
      drive_a(30);
      wait_drain();

      test_name = "lane_b_only";
      drive_b(30);
      wait_drain();

      test_name = "both_lanes";
      max_delay <= 3;
      fork
         drive_a(60);
         drive_b(60);
      join
      wait_drain();

      test_name = "overflow";
      overflows = 0;
      hold_ack <= 1'b1;
      flood_a(flood_len);
      @(posedge rdclk);
      hold_ack <= 1'b0;
      wait_drain();
      assert (overflows > 0) else report_problem("lane a never overflowed while ack was held");

      test_name = "drain";
      repeat (20) begin
         @(posedge rdclk);
         assert (!wb.stb) else report_problem("a bus write came out after all queues drained");
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== dual_lane_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module dual_lane_bridge (
   input  logic                wrclk,
   input  logic                rdclk,
   input  logic                arst_n,
   input  bridge_pkg::sample_t a_data,
   input  logic                a_write,
   output logic                a_full,
   output logic                a_overflow,
   input  bridge_pkg::event_t  b_data,
   input  logic                b_write,
   output logic                b_full,
   output logic                b_overflow,
   output bridge_pkg::wb_req_t wb,
   input  logic                wb_ack
);

   bridge_pkg::sample_t a_rd_data;
   logic                a_empty;
   logic                a_pop;
   bridge_pkg::event_t  b_rd_data;
   logic                b_empty;
   logic                b_pop;

   // the bus type and the settings header must agree on address width.
   if ($bits(wb.adr) != `BRIDGE_WB_ADR_W) begin : g_adr_w_check
      $error("wishbone address field width differs from BRIDGE_WB_ADR_W");
   end

   afifo_channel #(
      .payload_t (bridge_pkg::sample_t)
   ) u_lane_a (
      .wrclk    (wrclk),
      .rdclk    (rdclk),
      .arst_n   (arst_n),
      .wr_data  (a_data),
      .write    (a_write),
      .full     (a_full),
      .overflow (a_overflow),
      .rd_data  (a_rd_data),
      .empty    (a_empty),
      .pop      (a_pop)
   );

   afifo_channel #(
      .payload_t (bridge_pkg::event_t)
   ) u_lane_b (
      .wrclk    (wrclk),
      .rdclk    (rdclk),
      .arst_n   (arst_n),
      .wr_data  (b_data),
      .write    (b_write),
      .full     (b_full),
      .overflow (b_overflow),
      .rd_data  (b_rd_data),
      .empty    (b_empty),
      .pop      (b_pop)
   );

   lane_merge u_merge (
      .rdclk   (rdclk),
      .arst_n  (arst_n),
      .a_data  (a_rd_data),
      .a_empty (a_empty),
      .a_pop   (a_pop),
      .b_data  (b_rd_data),
      .b_empty (b_empty),
      .b_pop   (b_pop),
      .wb      (wb),
      .wb_ack  (wb_ack)
   );

endmodule

// ==== lane_merge.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module lane_merge (
   input  logic                rdclk,
   input  logic                arst_n,
   input  bridge_pkg::sample_t a_data,
   input  logic                a_empty,
   output logic                a_pop,
   input  bridge_pkg::event_t  b_data,
   input  logic                b_empty,
   output logic                b_pop,
   output bridge_pkg::wb_req_t wb,
   input  logic                wb_ack
);

   logic [1:0]                  rst_sync;
   logic                        rst_n;

   bridge_pkg::lane_e           last_q;
   logic                        busy_q;
   logic [`BRIDGE_WB_ADR_W-1:0] adr_q;
   logic [31:0]                 dat_q;

   logic                        free;
   logic                        pick_a;
   logic                        pick_b;
   logic [31:0]                 a_word;
   logic [31:0]                 b_word;

   always_ff @(posedge rdclk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign rst_n = rst_sync[1];

   assign a_word = {{16{a_data[15]}}, a_data};               // sign-extended.
   assign b_word = {8'h00, b_data.code, b_data.stamp};

   // the bus register is free when idle or being acked now.
   assign free = ~busy_q | wb_ack;

   always_comb begin
      pick_a = 1'b0;
      pick_b = 1'b0;
      if (free) begin
         if (!a_empty && !b_empty) begin
            pick_a = (last_q == bridge_pkg::lane_b);
            pick_b = (last_q == bridge_pkg::lane_a);
         end else begin
            pick_a = ~a_empty;
            pick_b = ~b_empty;
         end
      end
   end

   assign a_pop = pick_a;
   assign b_pop = pick_b;

   always_ff @(posedge rdclk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         last_q <= bridge_pkg::lane_b;
      end else if (pick_a) begin
         busy_q <= 1'b1;
         last_q <= bridge_pkg::lane_a;
      end else if (pick_b) begin
         busy_q <= 1'b1;
         last_q <= bridge_pkg::lane_b;
      end else if (wb_ack) begin
         busy_q <= 1'b0;
      end
   end

   always_ff @(posedge rdclk) begin
      if (pick_a) begin
         adr_q <= `BRIDGE_LANE_A_ADR;
         dat_q <= a_word;
      end else if (pick_b) begin
         adr_q <= `BRIDGE_LANE_B_ADR;
         dat_q <= b_word;
      end
   end

   assign wb = '{cyc: busy_q, stb: busy_q, we: 1'b1, adr: adr_q, dat: dat_q, sel: 4'hf};

   wb_hold_until_ack: assert property (
      @(posedge rdclk) disable iff (!rst_n)
      (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.dat))
   );

   single_pop: assert property (
      @(posedge rdclk) disable iff (!rst_n)
      !(a_pop && b_pop)
   );

endmodule

// ==== afifo_channel.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module afifo_channel #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     wrclk,
   input  logic     rdclk,
   input  logic     arst_n,
   input  payload_t wr_data,
   input  logic     write,
   output logic     full,
   output logic     overflow,
   output payload_t rd_data,
   output logic     empty,
   input  logic     pop
);

   localparam int aw    = `BRIDGE_DEPTH_RADIX;
   localparam int depth = 1 << aw;

   logic [1:0]  wr_rst_sync;
   logic [1:0]  rd_rst_sync;
   logic        wr_rst_n;
   logic        rd_rst_n;

   payload_t    mem [depth];

   logic [aw:0] wr_bin;
   logic [aw:0] wr_gray;
   logic [aw:0] wr_bin_next;
   logic [aw:0] wr_gray_next;
   logic [aw:0] rd_bin;
   logic [aw:0] rd_gray;
   logic [aw:0] rd_bin_next;
   logic [aw:0] rd_gray_next;

   logic [aw:0] rd_gray_w1;     // read pointer into wrclk.
   logic [aw:0] rd_gray_w2;
   logic [aw:0] wr_gray_r1;     // write pointer into rdclk.
   logic [aw:0] wr_gray_r2;

   logic        wr_en;
   logic        rd_en;

   // assert at once, release two edges later in each domain.
   always_ff @(posedge wrclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_rst_sync <= 2'b00;
      end else begin
         wr_rst_sync <= {wr_rst_sync[0], 1'b1};
      end
   end

   always_ff @(posedge rdclk or negedge arst_n) begin
      if (!arst_n) begin
         rd_rst_sync <= 2'b00;
      end else begin
         rd_rst_sync <= {rd_rst_sync[0], 1'b1};
      end
   end

   assign wr_rst_n = wr_rst_sync[1];
   assign rd_rst_n = rd_rst_sync[1];

   assign wr_en        = write & ~full;
   assign overflow     = write & full;  // the word is dropped.
   assign wr_bin_next  = wr_bin + (aw + 1)'(wr_en);
   assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

   always_ff @(posedge wrclk) begin
      if (wr_en) begin
         mem[wr_bin[aw-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge wrclk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         wr_bin     <= wr_bin_next;
         wr_gray    <= wr_gray_next;
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
      end
   end

   // full when the writer is one lap ahead of the reader.
   assign full = (wr_gray == {~rd_gray_w2[aw:aw-1], rd_gray_w2[aw-2:0]});

   assign rd_en        = pop & ~empty;
   assign rd_bin_next  = rd_bin + (aw + 1)'(rd_en);
   assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

   always_ff @(posedge rdclk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         rd_bin     <= rd_bin_next;
         rd_gray    <= rd_gray_next;
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
      end
   end

   assign empty   = (rd_gray == wr_gray_r2);
   assign rd_data = mem[rd_bin[aw-1:0]];  // show-ahead head word.

   wr_ptr_held_when_full: assert property (
      @(posedge wrclk) disable iff (!wr_rst_n)
      full |=> $stable(wr_bin)
   );

   rd_ptr_held_when_empty: assert property (
      @(posedge rdclk) disable iff (!rd_rst_n)
      empty |=> $stable(rd_bin)
   );

endmodule

// ==== bridge_pkg.sv ====
package bridge_pkg;

   // lane a payload.
   typedef logic signed [15:0] sample_t;

   // lane b payload of 24 bits.
   typedef struct packed {
      logic [7:0]  code;
      logic [15:0] stamp;
   } event_t;

   typedef enum logic {
      lane_a = 1'b0,
      lane_b = 1'b1
   } lane_e;

   // master to slave side of a wishbone classic port.
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;  // BRIDGE_WB_ADR_W bits.
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

endpackage

// ==== bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// fifo holds 2**radix words per lane.
`define BRIDGE_DEPTH_RADIX 3

// wishbone address width.
`define BRIDGE_WB_ADR_W 16

// write addresses that name the source lane.
`define BRIDGE_LANE_A_ADR 16'h0010
`define BRIDGE_LANE_B_ADR 16'h0020

`endif
